// File: sim.f
common/knight_pkg.sv
tour_logic/tour_logic.sv
tour_cmd/tour_cmd.sv
logic/knight_tour_top.sv
dv/tb_clock_gen.sv
dv/knight_tour_checker.sv
dv/knight_tour_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compiles the knight's tour testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f \
  --top-module knight_tour_tb -Mdir obj_dir -o knight_tour_sim

status=0
./obj_dir/knight_tour_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "^Simulation completed successfully$" sim.log; then
  echo "PASS"
  exit 0
fi
echo "FAIL (simulator exit status $status)"
exit 1

// File: dv/knight_tour_tb.sv
`timescale 1ns/1ps
`default_nettype none

module knight_tour_tb
  import knight_pkg::*;
();

  localparam int SEED            = 7526;
  localparam int NUM_TOURS       = 3;          // Tours actually started below.
  localparam int CYCLES_PER_TOUR = 2_000_000;  // Generous bound on one search plus replay.
  localparam int ILLEGAL_TRIES   = 4;
  localparam int QUIET_CYCLES    = 20;         // Watch window after a rejected go.
  localparam int CYCLE_LIMIT     = NUM_TOURS * CYCLES_PER_TOUR +
                                   ILLEGAL_TRIES * (QUIET_CYCLES + 2) + 200;
  // Knight offsets, indexed by the bit position of the one-hot move.
  localparam int DX [8] = '{1, -1, -2, -2, -1, 1, 2, 2};
  localparam int DY [8] = '{2, 2, 1, -1, -2, -2, -1, 1};

  typedef logic [TOUR_MOVES-1:0][7:0] tour_t;  // Moves 0 to 23 of one tour.

  logic     clk, rst_n, go, busy, cmd_strobe, tour_complete;
  coord_t   x_start, y_start;
  heading_t cmd_heading;
  squares_t cmd_squares;

  logic [3:0] exp_legs [$];  // Pending legs as {heading, squares}.
  int errors = 0, checks = 0, legs_seen = 0, total_legs = 0, tours_done = 0, cycles = 0;
  int pos_x, pos_y, visits;  // Robot position replayed from the legs.
  bit visited [BOARD_SIZE][BOARD_SIZE];
  bit prev_strobe = 1'b0;

  tb_clock_gen clock_gen_inst (.clk(clk), .rst_n(rst_n));

  knight_tour_top knight_tour_top_inst (
    .clk(clk), .rst_n(rst_n), .go(go), .x_start(x_start), .y_start(y_start),
    .busy(busy), .cmd_strobe(cmd_strobe), .cmd_heading(cmd_heading),
    .cmd_squares(cmd_squares), .tour_complete(tour_complete)
  );

  bind tour_cmd knight_tour_checker knight_tour_checker_inst (
    .clk(clk), .rst_n(rst_n), .busy(busy), .cmd_strobe(cmd_strobe),
    .cmd_squares(cmd_squares), .tour_complete(tour_complete)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  // Depth-first search that always tries the lowest move bit first.
  function automatic tour_t ref_tour(input int sx, input int sy);
    tour_t path;
    int    px [TOUR_MOVES+1];
    int    py [TOUR_MOVES+1];
    int    next_bit [TOUR_MOVES+1];  // First bit still untried at each depth.
    bit    seen [BOARD_SIZE][BOARD_SIZE];
    int    depth, b, nx, ny;
    bit    stepped;
    path  = '0;
    seen  = '{default: '0};
    depth = 0;
    px[0] = sx;
    py[0] = sy;
    next_bit[0] = 0;
    seen[sx][sy] = 1'b1;
    while (depth >= 0 && depth < TOUR_MOVES) begin
      stepped = 1'b0;
      b = next_bit[depth];
      while (b < 8 && !stepped) begin
        nx = px[depth] + DX[b];
        ny = py[depth] + DY[b];
        if (nx >= 0 && nx < BOARD_SIZE && ny >= 0 && ny < BOARD_SIZE && !seen[nx][ny]) begin
          path[depth]     = move_t'(1 << b);
          next_bit[depth] = b + 1;     // Resume past this bit when unwinding.
          depth++;
          px[depth] = nx;
          py[depth] = ny;
          next_bit[depth] = 0;
          seen[nx][ny] = 1'b1;
          stepped = 1'b1;
        end else begin
          b++;
        end
      end
      if (!stepped) begin
        seen[px[depth]][py[depth]] = 1'b0;  // A dead end gives its square back.
        depth--;
      end
    end
    return path;
  endfunction

  // One leg of a move. The long leg runs along the axis whose offset is 2.
  function automatic logic [3:0] leg_of(input int b, input bit long_leg);
    heading_t h;
    bit       use_x;
    use_x = ((DX[b] == 2 || DX[b] == -2) == long_leg);
    if (use_x)
      h = (DX[b] > 0) ? HEAD_EAST : HEAD_WEST;
    else
      h = (DY[b] > 0) ? HEAD_NORTH : HEAD_SOUTH;
    return {h, long_leg ? 2'd2 : 2'd1};
  endfunction

  function automatic int bit_index(input move_t m);
    int idx;
    int i;
    idx = -1;                  // Stays negative for an empty move.
    for (i = 0; i < 8; i++)
      if (m[i])
        idx = i;
    return idx;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus tasks
  ////////////////////////////////////////////////////////////////////////////

  // Called 1 ns after an edge and returns 1 ns after the next one.
  task automatic drive_go(input int x, input int y);
    x_start = coord_t'(x);
    y_start = coord_t'(y);
    go      = 1'b1;
    @(posedge clk);
    #1;
    go      = 1'b0;
  endtask

  task automatic pick_legal(input int avoid_x, input int avoid_y, output int x, output int y);
    do begin
      x = $urandom % BOARD_SIZE;
      y = $urandom % BOARD_SIZE;
    end while (((x + y) % 2 != 0) || (x == avoid_x && y == avoid_y));
  endtask

  task automatic start_tour(input int x, input int y);
    tour_t path;
    int    i, j, b;
    path = ref_tour(x, y);
    for (i = 0; i < TOUR_MOVES; i++) begin
      b = bit_index(path[i]);
      if (b < 0) begin
        errors++;
        $display("reference search found no move %0d from (%0d,%0d)", i, x, y);
      end else begin
        exp_legs.push_back(leg_of(b, 1'b1));  // Two-square leg goes first.
        exp_legs.push_back(leg_of(b, 1'b0));
      end
    end
    for (i = 0; i < BOARD_SIZE; i++)
      for (j = 0; j < BOARD_SIZE; j++)
        visited[i][j] = 1'b0;
    pos_x = x;
    pos_y = y;
    visited[x][y] = 1'b1;
    visits    = 1;
    legs_seen = 0;
    drive_go(x, y);
    checks++;
    if (busy !== 1'b1) begin
      errors++;
      $display("error at %0t: busy expected 1, got %b", $time, busy);
    end
  endtask

  // A rejected go must leave the DUT silent for the whole window.
  task automatic try_illegal(input int x, input int y);
    int i;
    drive_go(x, y);
    for (i = 0; i < QUIET_CYCLES; i++) begin
      checks++;
      if (busy !== 1'b0) begin
        errors++;
        $display("error at %0t: busy expected 0, got %b", $time, busy);
      end
      @(posedge clk);
      #1;
    end
  endtask

  task automatic wait_tour_end();
    do @(negedge clk); while (tour_complete !== 1'b1);
    @(posedge clk);
    #1;
    checks++;
    if (exp_legs.size() != 0) begin
      errors++;
      $display("tour ended with %0d expected legs never issued", exp_legs.size());
    end
  endtask

  task automatic finish_run();
    $display("checks %0d, legs %0d, tours %0d, errors %0d",
             checks, total_legs, tours_done, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Compare and legality tracking
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_leg();
    logic [3:0] exp;
    if (exp_legs.size() == 0) begin
      errors++;
      $display("command strobe at %0t with no leg expected", $time);
    end else begin
      exp = exp_legs.pop_front();
      legs_seen++;
      total_legs++;
      checks++;
      if (cmd_heading !== heading_t'(exp[3:2])) begin
        errors++;
        $display("error at %0t: cmd_heading expected %0d, got %0d", $time, exp[3:2], cmd_heading);
      end
      if (cmd_squares !== exp[1:0]) begin
        errors++;
        $display("error at %0t: cmd_squares expected %0d, got %0d", $time, exp[1:0], cmd_squares);
      end
    end
    case (cmd_heading)      // Move the robot by what the DUT actually commanded.
      HEAD_NORTH: pos_y += int'(cmd_squares);
      HEAD_EAST:  pos_x += int'(cmd_squares);
      HEAD_SOUTH: pos_y -= int'(cmd_squares);
      default:    pos_x -= int'(cmd_squares);
    endcase
    if (pos_x < 0 || pos_x >= BOARD_SIZE || pos_y < 0 || pos_y >= BOARD_SIZE) begin
      errors++;
      $display("leg %0d leaves the board at (%0d,%0d)", legs_seen, pos_x, pos_y);
    end else if (cmd_squares == 2'd1) begin
      if (visited[pos_x][pos_y]) begin   // A move ends after its short leg.
        errors++;
        $display("move lands on square (%0d,%0d) a second time", pos_x, pos_y);
      end else begin
        visited[pos_x][pos_y] = 1'b1;
        visits++;
      end
    end
  endtask

  task automatic check_complete();
    checks++;
    if (legs_seen != 2 * TOUR_MOVES) begin
      errors++;
      $display("error at %0t: legs before tour_complete expected %0d, got %0d",
               $time, 2 * TOUR_MOVES, legs_seen);
    end
    if (cmd_strobe || !prev_strobe) begin
      errors++;
      $display("tour_complete did not come on the cycle right after the last leg");
    end
    if (busy !== 1'b0) begin
      errors++;
      $display("error at %0t: busy expected 0, got %b", $time, busy);
    end
    if (visits != BOARD_SIZE * BOARD_SIZE) begin
      errors++;
      $display("error at %0t: visited squares expected 25, got %0d", $time, visits);
    end
    tours_done++;
    legs_seen = 0;   // A second pulse would now fail the leg count.
  endtask

  // Outputs settle well before the falling edge.
  always @(negedge clk) begin
    if (rst_n) begin
      if (cmd_strobe)
        check_leg();
      if (tour_complete)
        check_complete();
      prev_strobe = cmd_strobe;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      errors++;
      $display("timeout after %0d cycles, the tours did not finish", cycles);
      finish_run();
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int seed_val, x, y, x2, y2, i;
    go       = 1'b0;
    x_start  = '0;
    y_start  = '0;
    seed_val = $urandom(SEED);
    wait (rst_n === 1'b1);
    @(posedge clk);
    #1;
    checks++;
    if (busy !== 1'b0) begin
      errors++;
      $display("error at %0t: busy expected 0, got %b", $time, busy);
    end
    if (cmd_strobe !== 1'b0) begin
      errors++;
      $display("error at %0t: cmd_strobe expected 0, got %b", $time, cmd_strobe);
    end
    if (tour_complete !== 1'b0) begin
      errors++;
      $display("error at %0t: tour_complete expected 0, got %b", $time, tour_complete);
    end
    for (i = 0; i < 2; i++) begin   // Odd-parity squares on the board.
      x = $urandom % BOARD_SIZE;
      y = $urandom % BOARD_SIZE;
      if ((x + y) % 2 == 0)
        y = (y == 0) ? 1 : y - 1;
      try_illegal(x, y);
    end
    try_illegal(5 + $urandom % 3, $urandom % BOARD_SIZE);  // x off the board.
    try_illegal($urandom % BOARD_SIZE, 5 + $urandom % 3);  // y off the board.
    // First tour, hit twice by a go that must be ignored.
    pick_legal(-1, -1, x, y);
    start_tour(x, y);
    pick_legal(x, y, x2, y2);
    drive_go(x2, y2);               // Arrives while the solver runs.
    do @(negedge clk); while (cmd_strobe !== 1'b1);
    @(posedge clk);
    #1;
    drive_go(x2, y2);               // Arrives during the replay.
    checks++;
    if (busy !== 1'b1) begin
      errors++;
      $display("error at %0t: busy expected 1, got %b", $time, busy);
    end
    wait_tour_end();
    // Two tours back to back from different squares.
    pick_legal(x, y, x2, y2);
    start_tour(x2, y2);
    wait_tour_end();
    pick_legal(x2, y2, x, y);
    start_tour(x, y);
    wait_tour_end();
    finish_run();
  end

endmodule : knight_tour_tb

`default_nettype wire

// File: dv/knight_tour_checker.sv
`timescale 1ns/1ps
`default_nettype none

module knight_tour_checker
  import knight_pkg::*;
(
  input logic     clk,
  input logic     rst_n,
  input logic     busy,
  input logic     cmd_strobe,
  input squares_t cmd_squares,
  input logic     tour_complete
);

  // A strobe belongs to an active run, or to the very cycle the run ends in.
  strobe_in_run: assert property (@(posedge clk) disable iff (!rst_n)
    (cmd_strobe || tour_complete) |-> (busy || $fell(busy)))
    else $error("command or completion strobe seen outside a run");

  // Legs are only ever one or two squares long.
  squares_legal: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_strobe |-> (cmd_squares == 2'd1 || cmd_squares == 2'd2))
    else $error("leg length %0d is neither 1 nor 2", cmd_squares);

  // Every long leg is followed at once by its short leg.
  long_then_short: assert property (@(posedge clk) disable iff (!rst_n)
    (cmd_strobe && cmd_squares == 2'd2) |=> (cmd_strobe && cmd_squares == 2'd1))
    else $error("long leg not followed by a short leg");

  // After a short leg comes the next long leg or the end of the run.
  short_then_long: assert property (@(posedge clk) disable iff (!rst_n)
    (cmd_strobe && cmd_squares == 2'd1) |=> (!cmd_strobe || cmd_squares == 2'd2))
    else $error("short leg followed by another short leg");

  first_leg_long: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(cmd_strobe) |-> (cmd_squares == 2'd2))
    else $error("run opened with a short leg");  // Runs open with a long leg.

endmodule : knight_tour_checker

`default_nettype wire

// File: dv/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clk,
  output logic rst_n
);

  localparam int HALF_PERIOD  = 4;  // Gives the 8 ns clock period.
  localparam int RESET_CYCLES = 5;  // Rising edges seen with reset held low.

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // Reset is released just after an edge so it never races the flops.
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 rst_n = 1'b1;
  end

endmodule : tb_clock_gen

`default_nettype wire

// File: logic/knight_tour_top.sv
`timescale 1ns/1ps
`default_nettype none

module knight_tour_top
  import knight_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     go,             // Start strobe, ignored while busy.
  input  coord_t   x_start,
  input  coord_t   y_start,
  output logic     busy,
  output logic     cmd_strobe,     // One leg per strobe, no back-pressure.
  output heading_t cmd_heading,
  output squares_t cmd_squares,
  output logic     tour_complete
);

  logic      solve_go;    // Filtered start into the solver.
  logic      solve_done;  // Solver finished strobe.
  move_idx_t rd_indx;     // Replay read address.
  move_t     rd_move;     // Move returned for rd_indx.

  // Solver. It holds the tour until the next accepted go.
  tour_logic tour_logic_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .go      (solve_go),
    .x_start (x_start),
    .y_start (y_start),
    .indx    (rd_indx),
    .done    (solve_done),
    .move    (rd_move)
  );

  // Replayer. It also owns busy and the start-square filter.
  tour_cmd tour_cmd_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .go_req        (go),
    .x_start       (x_start),
    .y_start       (y_start),
    .done          (solve_done),
    .move          (rd_move),
    .go            (solve_go),
    .indx          (rd_indx),
    .busy          (busy),
    .cmd_strobe    (cmd_strobe),
    .cmd_heading   (cmd_heading),
    .cmd_squares   (cmd_squares),
    .tour_complete (tour_complete)
  );

endmodule : knight_tour_top

`default_nettype wire

// File: tour_cmd/tour_cmd.sv
`timescale 1ns/1ps
`default_nettype none

module tour_cmd
  import knight_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      go_req,         // Start request from outside.
  input  coord_t    x_start,        // Checked here before go is forwarded.
  input  coord_t    y_start,
  input  logic      done,           // Solver has the full tour stored.
  input  move_t     move,           // Stored move at indx.
  output logic      go,             // Forwarded start for the solver.
  output move_idx_t indx,
  output logic      busy,
  output logic      cmd_strobe,
  output heading_t  cmd_heading,
  output squares_t  cmd_squares,
  output logic      tour_complete
);

  // SOLVE waits on the solver. LONG and SHORT alternate once per move.
  typedef enum logic [1:0] {CMD_IDLE, CMD_SOLVE, CMD_LONG, CMD_SHORT} cmd_state_t;

  cmd_state_t state, nxt_state;

  logic     start_legal;    // Start square can begin a tour.
  logic     last_leg;       // Short leg of move 23 is on the outputs.
  heading_t long_heading;   // Heading of the two-square axis.
  heading_t short_heading;  // Heading of the one-square axis.

  ////////////////////////////////////////////////////////////////////////////
  // Start acceptance
  ////////////////////////////////////////////////////////////////////////////

  // A 5x5 tour only exists from squares where x+y is even.
  assign start_legal = (x_start < coord_t'(BOARD_SIZE)) &&
                       (y_start < coord_t'(BOARD_SIZE)) &&
                       (x_start[0] == y_start[0]);

  assign go       = go_req && !busy && start_legal;  // Dropped while a run is active.
  assign busy     = (state != CMD_IDLE);
  assign last_leg = (state == CMD_SHORT) && (indx == move_idx_t'(LAST_MOVE_IDX));

  ////////////////////////////////////////////////////////////////////////////
  // Replay FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
    if (!rst_n)
      state <= CMD_IDLE;
    else
      state <= nxt_state;

  always_comb begin
    nxt_state = state;
    case (state)
      CMD_IDLE:  if (go) nxt_state = CMD_SOLVE;
      CMD_SOLVE: if (done) nxt_state = CMD_LONG;
      CMD_LONG:  nxt_state = CMD_SHORT;              // Every move has two legs.
      default:   nxt_state = last_leg ? CMD_IDLE : CMD_LONG;
    endcase
  end

  // The index is zeroed with done and steps after each short leg.
  always_ff @(posedge clk or negedge rst_n)
    if (!rst_n)
      indx <= '0;
    else if ((state == CMD_SOLVE) && done)
      indx <= '0;
    else if ((state == CMD_SHORT) && !last_leg)
      indx <= indx + 1'b1;

  // Pulses as the machine drops back to idle, together with busy.
  always_ff @(posedge clk or negedge rst_n)
    if (!rst_n)
      tour_complete <= 1'b0;
    else
      tour_complete <= last_leg;

  ////////////////////////////////////////////////////////////////////////////
  // Leg decode
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (move)
      8'h01:   begin long_heading = HEAD_NORTH; short_heading = HEAD_EAST;  end  // (+1,+2)
      8'h02:   begin long_heading = HEAD_NORTH; short_heading = HEAD_WEST;  end  // (-1,+2)
      8'h04:   begin long_heading = HEAD_WEST;  short_heading = HEAD_NORTH; end  // (-2,+1)
      8'h08:   begin long_heading = HEAD_WEST;  short_heading = HEAD_SOUTH; end  // (-2,-1)
      8'h10:   begin long_heading = HEAD_SOUTH; short_heading = HEAD_WEST;  end  // (-1,-2)
      8'h20:   begin long_heading = HEAD_SOUTH; short_heading = HEAD_EAST;  end  // (+1,-2)
      8'h40:   begin long_heading = HEAD_EAST;  short_heading = HEAD_SOUTH; end  // (+2,-1)
      8'h80:   begin long_heading = HEAD_EAST;  short_heading = HEAD_NORTH; end  // (+2,+1)
      default: begin long_heading = HEAD_NORTH; short_heading = HEAD_NORTH; end
    endcase
  end

  assign cmd_strobe  = (state == CMD_LONG) || (state == CMD_SHORT);
  assign cmd_heading = (state == CMD_SHORT) ? short_heading : long_heading;
  assign cmd_squares = (state == CMD_SHORT) ? squares_t'(1) : squares_t'(2);

endmodule : tour_cmd

`default_nettype wire

// File: tour_logic/tour_logic.sv
`timescale 1ns/1ps
`default_nettype none

module tour_logic
  import knight_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      go,        // Start a search. Only legal squares arrive here.
  input  coord_t    x_start,
  input  coord_t    y_start,
  input  move_idx_t indx,      // Read address into the stored tour.
  output logic      done,      // One cycle when the 24th move is placed.
  output move_t     move       // Stored move at indx.
);

  // The search walks forward until it is stuck, then unwinds to the most
  // recent square that still has untried moves.
  typedef enum logic [2:0] {IDLE, INIT, POSSIBLE, MAKE_MOVE, BACKUP} state_t;

  state_t state, nxt_state;

  logic [BOARD_SIZE-1:0] board [BOARD_SIZE];  // Visited flags, indexed [x][y].
  move_t     last_move  [TOUR_MOVES];         // Move taken out of each step.
  move_t     poss_moves [TOUR_MOVES];         // In-bounds moves from each step.
  move_t     move_try;                        // Candidate under test.
  move_idx_t move_num;                        // Depth of the current square.
  move_idx_t prev_num;                        // Depth one step back.
  coord_t    xx, yy;                          // Knight position.
  coord_t    start_x, start_y;                // Start square held from go.
  coord_t    nxt_xx_inc, nxt_yy_inc;          // Landing square of move_try.
  coord_t    nxt_xx_dec, nxt_yy_dec;          // Square we came from.

  logic move_poss;       // Candidate lands on the board on a fresh square.
  logic have_move;       // Candidate is not yet the last bit.
  logic prev_have_move;  // Square we backed into still has untried moves.
  logic tour_done;       // The move about to be placed is the final one.

  logic zero, init, calc, update_position, next_move, backup;  // FSM controls.

  ////////////////////////////////////////////////////////////////////////////
  // Move geometry
  ////////////////////////////////////////////////////////////////////////////

  // Moves that stay on the board, as the AND of an x mask and a y mask.
  function automatic move_t calc_poss(input coord_t xpos, input coord_t ypos);
    move_t x_ok;
    move_t y_ok;
    case (xpos)
      3'd0:    x_ok = 8'b1110_0001;  // Nothing with a negative x step.
      3'd1:    x_ok = 8'b1111_0011;  // No -2 steps in x.
      3'd2:    x_ok = 8'b1111_1111;
      3'd3:    x_ok = 8'b0011_1111;  // No +2 steps in x.
      3'd4:    x_ok = 8'b0001_1110;  // Nothing with a positive x step.
      default: x_ok = '0;
    endcase
    case (ypos)
      3'd0:    y_ok = 8'b1000_0111;
      3'd1:    y_ok = 8'b1100_1111;
      3'd2:    y_ok = 8'b1111_1111;
      3'd3:    y_ok = 8'b1111_1100;
      3'd4:    y_ok = 8'b0111_1000;
      default: y_ok = '0;
    endcase
    return x_ok & y_ok;
  endfunction

  // X step of a move in three-bit two's complement.
  function automatic coord_t off_x(input move_t m);
    case (m)
      8'h01, 8'h20: off_x = 3'd1;  // +1
      8'h02, 8'h10: off_x = 3'd7;  // -1
      8'h04, 8'h08: off_x = 3'd6;  // -2
      8'h40, 8'h80: off_x = 3'd2;  // +2
      default:      off_x = 3'd0;
    endcase
  endfunction

  // Y step of a move in three-bit two's complement.
  function automatic coord_t off_y(input move_t m);
    case (m)
      8'h04, 8'h80: off_y = 3'd1;  // +1
      8'h08, 8'h40: off_y = 3'd7;  // -1
      8'h10, 8'h20: off_y = 3'd6;  // -2
      8'h01, 8'h02: off_y = 3'd2;  // +2
      default:      off_y = 3'd0;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////////////////////

  assign prev_num   = move_num - 1'b1;
  assign nxt_xx_inc = xx + off_x(move_try);             // Forward landing x.
  assign nxt_yy_inc = yy + off_y(move_try);             // Forward landing y.
  assign nxt_xx_dec = xx - off_x(last_move[prev_num]);  // Undo the last step.
  assign nxt_yy_dec = yy - off_y(last_move[prev_num]);

  // The start square is captured with the go strobe itself.
  always_ff @(posedge clk)
    if (zero) begin
      start_x <= x_start;
      start_y <= y_start;
    end

  // Visited map. Backing up frees the square being left.
  always_ff @(posedge clk)
    if (zero)
      board <= '{default: '0};
    else if (init)
      board[start_x][start_y] <= 1'b1;
    else if (update_position)
      board[nxt_xx_inc][nxt_yy_inc] <= 1'b1;
    else if (backup)
      board[xx][yy] <= 1'b0;

  always_ff @(posedge clk)
    if (init) begin
      xx <= start_x;
      yy <= start_y;
    end else if (update_position) begin
      xx <= nxt_xx_inc;
      yy <= nxt_yy_inc;
    end else if (backup) begin
      xx <= nxt_xx_dec;
      yy <= nxt_yy_dec;
    end

  // On backup the search resumes one bit past the move that failed.
  always_ff @(posedge clk)
    if (calc)
      move_try <= 8'h01;
    else if (next_move)
      move_try <= {move_try[6:0], 1'b0};
    else if (backup)
      move_try <= {last_move[prev_num][6:0], 1'b0};

  always_ff @(posedge clk or negedge rst_n)
    if (!rst_n)
      move_num <= '0;
    else if (zero)
      move_num <= '0;
    else if (update_position)
      move_num <= move_num + 1'b1;
    else if (backup)
      move_num <= prev_num;

  always_ff @(posedge clk)
    if (calc)
      poss_moves[move_num] <= calc_poss(xx, yy);

  // Only moves actually taken are recorded, so the array ends as the tour.
  always_ff @(posedge clk)
    if (update_position)
      last_move[move_num] <= move_try;

  assign have_move      = (move_try != 8'h80);
  assign prev_have_move = (last_move[move_num] != 8'h80);
  assign move_poss      = (|(poss_moves[move_num] & move_try)) &&
                          !board[nxt_xx_inc][nxt_yy_inc];
  assign tour_done      = (move_num == move_idx_t'(LAST_MOVE_IDX));
  assign move           = last_move[indx];  // Read port for the replayer.

  ////////////////////////////////////////////////////////////////////////////
  // Search FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
    if (!rst_n)
      state <= IDLE;
    else
      state <= nxt_state;

  always_comb begin
    nxt_state       = state;
    zero            = 1'b0;
    init            = 1'b0;
    calc            = 1'b0;
    update_position = 1'b0;
    next_move       = 1'b0;
    backup          = 1'b0;
    done            = 1'b0;
    case (state)
      INIT: begin
        init      = 1'b1;       // Mark the start square.
        nxt_state = POSSIBLE;
      end
      POSSIBLE: begin
        calc      = 1'b1;       // Latch the in-bounds mask for this depth.
        nxt_state = MAKE_MOVE;
      end
      MAKE_MOVE: begin
        if (move_poss) begin
          update_position = 1'b1;
          if (tour_done) begin
            done      = 1'b1;   // All 24 moves are stored now.
            nxt_state = IDLE;
          end else begin
            nxt_state = POSSIBLE;
          end
        end else if (have_move) begin
          next_move = 1'b1;     // Try the next bit at this depth.
        end else begin
          backup    = 1'b1;     // Every bit failed here.
          nxt_state = BACKUP;
        end
      end
      BACKUP: begin
        if (prev_have_move)
          nxt_state = MAKE_MOVE;
        else
          backup = 1'b1;        // That square was exhausted as well.
      end
      default: begin
        if (go) begin
          zero      = 1'b1;
          nxt_state = INIT;
        end
      end
    endcase
  end

endmodule : tour_logic

`default_nettype wire

// File: common/knight_pkg.sv
`default_nettype none

package knight_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Board geometry
  ////////////////////////////////////////////////////////////////////////////

  // The board is square. Every coordinate runs from 0 to BOARD_SIZE-1.
  localparam int BOARD_SIZE = 5;

  // A full tour visits 25 squares, which takes 24 moves after the start.
  localparam int TOUR_MOVES = 24;

  // Index of the final move stored by the solver.
  localparam int LAST_MOVE_IDX = 23;

  ////////////////////////////////////////////////////////////////////////////
  // Shared types
  ////////////////////////////////////////////////////////////////////////////

  // One board coordinate. Three bits leave room for the offset arithmetic,
  // which wraps modulo 8 when a move runs off the board.
  typedef logic [2:0] coord_t;

  // A knight move in one-hot form. The bit order also fixes the search order,
  // so the lowest set bit is always tried first.
  //   bit 0  (+1,+2)    bit 4  (-1,-2)
  //   bit 1  (-1,+2)    bit 5  (+1,-2)
  //   bit 2  (-2,+1)    bit 6  (+2,-1)
  //   bit 3  (-2,-1)    bit 7  (+2,+1)
  typedef logic [7:0] move_t;

  // Position of a move within the tour, 0 through 23.
  typedef logic [4:0] move_idx_t;

  // Direction of one straight leg of robot travel.
  typedef enum logic [1:0] {
    HEAD_NORTH = 2'd0,  // Toward larger y.
    HEAD_EAST  = 2'd1,  // Toward larger x.
    HEAD_SOUTH = 2'd2,  // Toward smaller y.
    HEAD_WEST  = 2'd3   // Toward smaller x.
  } heading_t;

  // Length of a leg in squares. Only 1 and 2 ever appear.
  typedef logic [1:0] squares_t;

endpackage : knight_pkg

`default_nettype wire
